// File: Makefile
VERILATOR ?= verilator
TOP       ?= cacheTb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
RUNARGS   ?= +verilator+error+limit+1000
PASS_TEXT ?= Simulation completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(RUNARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: hw/backingMem.sv
`timescale 1ns/1ps

module backingMem (
  input  logic               clk,
  input  logic               reset,
  input  logic               req,
  input  logic               write,
  input  cachePkg::lineAddrT lineAddr,
  input  cachePkg::lineT     wdata,
  output logic               done,
  output cachePkg::lineT     rdata
);

  import cachePkg::*;

  lineT                               memArray [2**$bits(lineAddrT)];
  logic                               active;
  logic [$clog2(memLatency+1)-1:0]    count;

  // Memory image starts cleared
  initial begin
    for (int i = 0; i < 2**$bits(lineAddrT); i++) memArray[i] = '0;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      active <= 1'b0;
      count  <= '0;
      done   <= 1'b0;
    end else begin
      done <= 1'b0;
      if (!active && req && !done) begin  // Request still up in the done cycle
        active <= 1'b1;
        count  <= ($bits(count))'(memLatency - 1);
      end else if (active) begin
        count <= count - 1'b1;
        if (count == 1) begin  // Done lands memLatency cycles after req
          active <= 1'b0;
          done   <= 1'b1;
        end
      end
    end
  end

  // Access happens on the edge that raises done
  always_ff @(posedge clk) begin
    if (active && count == 1) begin
      rdata <= memArray[lineAddr];
      if (write) memArray[lineAddr] <= wdata;
    end
  end

endmodule

// File: hw/cachePkg.sv
package cachePkg;

  // Geometry, all byte addressed
  localparam int addrBits   = 16;
  localparam int wordBytes  = 4;   // One request word
  localparam int lineBytes  = 16;  // Four words per line
  localparam int numSets    = 16;

  localparam int offsetBits = $clog2(lineBytes);
  localparam int setBits    = $clog2(numSets);
  localparam int tagBits    = addrBits - setBits - offsetBits;

  // Backing memory cycles per access
  localparam int memLatency = 4;

  //////////////////////////////
  // Shared types
  typedef logic [addrBits-1:0]         addrT;
  typedef logic [tagBits-1:0]          tagT;
  typedef logic [setBits-1:0]          setT;
  typedef logic [8*wordBytes-1:0]      wordT;
  typedef logic [wordBytes-1:0]        byteEnT;
  typedef logic [8*lineBytes-1:0]      lineT;
  typedef logic [tagBits+setBits-1:0]  lineAddrT;  // Tag above set
  typedef logic [lineBytes-1:0]        lineMaskT;  // One bit per line byte

endpackage

// File: hw/cacheTop.sv
`timescale 1ns/1ps

module cacheTop (
  input  logic             clk,
  input  logic             reset,
  input  logic             invalidate,
  // Port 0
  input  logic             p0ReqValid,
  input  logic             p0ReqWrite,
  input  cachePkg::addrT   p0ReqAddr,
  input  cachePkg::wordT   p0ReqWdata,
  input  cachePkg::byteEnT p0ReqByteEn,
  output logic             p0Busy,
  output logic             p0RspValid,
  output cachePkg::wordT   p0RspRdata,
  // Port 1
  input  logic             p1ReqValid,
  input  logic             p1ReqWrite,
  input  cachePkg::addrT   p1ReqAddr,
  input  cachePkg::wordT   p1ReqWdata,
  input  cachePkg::byteEnT p1ReqByteEn,
  output logic             p1Busy,
  output logic             p1RspValid,
  output cachePkg::wordT   p1RspRdata
);

  import cachePkg::*;

  logic     memReq0, memWrite0, memDone0, memReq1, memWrite1, memDone1;
  lineAddrT memLineAddr0, memLineAddr1, busLineAddr;
  lineT     memWdata0, memWdata1, memRdata0, memRdata1, busWdata, busRdata;
  logic     busReq, busWrite, busDone;

  dataCache cache0 (
    .clk, .reset, .invalidate, .reqValid(p0ReqValid), .reqWrite(p0ReqWrite),
    .reqAddr(p0ReqAddr), .reqWdata(p0ReqWdata), .reqByteEn(p0ReqByteEn),
    .busy(p0Busy), .rspValid(p0RspValid), .rspRdata(p0RspRdata),
    .memReq(memReq0), .memWrite(memWrite0), .memLineAddr(memLineAddr0),
    .memWdata(memWdata0), .memDone(memDone0), .memRdata(memRdata0)
  );

  dataCache cache1 (
    .clk, .reset, .invalidate, .reqValid(p1ReqValid), .reqWrite(p1ReqWrite),
    .reqAddr(p1ReqAddr), .reqWdata(p1ReqWdata), .reqByteEn(p1ReqByteEn),
    .busy(p1Busy), .rspValid(p1RspValid), .rspRdata(p1RspRdata),
    .memReq(memReq1), .memWrite(memWrite1), .memLineAddr(memLineAddr1),
    .memWdata(memWdata1), .memDone(memDone1), .memRdata(memRdata1)
  );

  // Shared line bus
  memArbiter arbiter (
    .clk, .reset,
    .req0(memReq0), .write0(memWrite0), .lineAddr0(memLineAddr0), .wdata0(memWdata0),
    .req1(memReq1), .write1(memWrite1), .lineAddr1(memLineAddr1), .wdata1(memWdata1),
    .memDoneIn(busDone), .memRdataIn(busRdata),
    .done0(memDone0), .done1(memDone1), .rdata0(memRdata0), .rdata1(memRdata1),
    .memReqOut(busReq), .memWriteOut(busWrite), .memLineAddrOut(busLineAddr),
    .memWdataOut(busWdata)
  );

  backingMem memory (
    .clk, .reset, .req(busReq), .write(busWrite), .lineAddr(busLineAddr),
    .wdata(busWdata), .done(busDone), .rdata(busRdata)
  );

endmodule

// File: hw/cacheWay.sv
`timescale 1ns/1ps

module cacheWay (
  input  logic               clk,
  input  logic               reset,
  input  logic               cacheEn,         // Enables RAM and status reads
  input  cachePkg::setT      set,
  input  cachePkg::tagT      lookupTag,
  input  cachePkg::lineT     lineWriteData,
  input  cachePkg::lineMaskT lineByteMask,
  input  logic               setValid,        // Fill completes into the victim
  input  logic               setDirty,        // Write hit
  input  logic               clearDirty,
  input  logic               victimWay,       // LRU picked this way
  input  logic               selWriteback,
  input  logic               invalidate,
  output cachePkg::lineT     readDataLineWay,
  output logic               hitWay,
  output logic               validWay,
  output logic               dirtyWay,
  output cachePkg::tagT      tagWay
);

  import cachePkg::*;

  logic [numSets-1:0] validBits;
  logic [numSets-1:0] dirtyBits;
  tagT                readTag;
  lineT               readLine;
  lineT               bitMask;
  lineMaskT           finalByteMask;
  logic               dirtyRead;
  logic               selData;
  logic               setValidWay, setDirtyWay, clearDirtyWay;

  //////////////////////////////
  // Way select and write enables
  assign selData       = (setValid | selWriteback) ? victimWay : hitWay;
  assign setValidWay   = setValid & selData;
  assign setDirtyWay   = setDirty & selData;
  assign clearDirtyWay = clearDirty & selData;

  assign finalByteMask = setValidWay ? '1 : lineByteMask;  // Fill writes the whole line

  always_comb begin
    for (int b = 0; b < lineBytes; b++) begin
      bitMask[8*b +: 8] = {8{finalByteMask[b]}};  // Byte enable to bit mask
    end
  end

  //////////////////////////////
  // Tag and data arrays
  sramArray #(.dataT(tagT), .depth(numSets)) tagMem (
    .clk, .ce(cacheEn), .addr(set), .we(setValidWay),
    .wmask('1), .din(lookupTag), .dout(readTag)
  );

  sramArray #(.dataT(lineT), .depth(numSets)) dataMem (
    .clk, .ce(cacheEn), .addr(set), .we(setValidWay | setDirtyWay),
    .wmask(bitMask), .din(lineWriteData), .dout(readLine)
  );

  //////////////////////////////
  // Valid and dirty state
  always_ff @(posedge clk) begin
    if (reset) begin
      validBits <= '0;
      validWay  <= 1'b0;
    end else begin
      if (cacheEn) validWay <= validBits[set];  // Aligned with RAM read
      if (invalidate) validBits <= '0;          // Global clear
      else if (setValidWay) validBits[set] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (cacheEn) dirtyRead <= dirtyBits[set];
    if (setDirtyWay | clearDirtyWay) dirtyBits[set] <= setDirtyWay;  // Set wins
  end

  // Hit compare and AND half of the way mux
  assign hitWay          = validWay & (readTag == lookupTag);
  assign readDataLineWay = selData ? readLine : '0;
  assign tagWay          = victimWay ? readTag : '0;
  assign dirtyWay        = victimWay & dirtyRead & validWay;  // Invalid lines never write back

endmodule

// File: hw/dataCache.sv
`timescale 1ns/1ps

module dataCache (
  input  logic               clk,
  input  logic               reset,
  input  logic               invalidate,
  input  logic               reqValid,
  input  logic               reqWrite,
  input  cachePkg::addrT     reqAddr,
  input  cachePkg::wordT     reqWdata,
  input  cachePkg::byteEnT   reqByteEn,
  output logic               busy,
  output logic               rspValid,
  output cachePkg::wordT     rspRdata,
  output logic               memReq,
  output logic               memWrite,
  output cachePkg::lineAddrT memLineAddr,
  output cachePkg::lineT     memWdata,
  input  logic               memDone,
  input  cachePkg::lineT     memRdata
);

  import cachePkg::*;

  typedef enum logic [2:0] {idle, lookup, writeback, fill, relookup} stateT;

  stateT state, nextState;
  logic  tagReady;  // Second cycle of a lookup, RAM outputs valid

  // Latched request
  logic                                       writeQ;
  setT                                        setQ;
  tagT                                        tagQ;
  logic [offsetBits-$clog2(wordBytes)-1:0]    wordIdxQ;
  wordT                                       wdataQ;
  byteEnT                                     byteEnQ;

  logic [numSets-1:0] lru;  // Index of the way to evict next
  lineT     rdLine0, rdLine1, readLine, lineWriteData;
  tagT      tag0, tag1, victimTag;
  logic     hit0, hit1, valid0, valid1, dirty0, dirty1;
  logic     hit, victimDirty, victimSel;
  logic     inLookup, checking, hitNow, accept;
  logic     cacheEn, setValid, setDirty, clearDirty, selWriteback, invalidateEn;
  lineMaskT lineByteMask;

  assign inLookup = (state == lookup) | (state == relookup);
  assign checking = inLookup & tagReady;
  assign hitNow   = checking & hit;

  assign rspValid = hitNow;
  assign busy     = (state != idle) & ~rspValid;  // Drops with the response
  assign accept   = reqValid & ~busy;

  always_ff @(posedge clk) begin
    if (accept) begin
      writeQ   <= reqWrite;
      {tagQ, setQ} <= reqAddr[addrBits-1:offsetBits];
      wordIdxQ <= reqAddr[offsetBits-1:$clog2(wordBytes)];
      wdataQ   <= reqWdata;
      byteEnQ  <= reqByteEn;
    end
  end

  //////////////////////////////
  // Way control
  assign setDirty     = hitNow & writeQ;
  assign setValid     = (state == fill) & memDone;
  assign clearDirty   = ((state == writeback) & memDone) | setValid;  // Fresh or written back
  assign selWriteback = (state == writeback);
  assign invalidateEn = invalidate & (state == idle);
  assign cacheEn      = (inLookup & ~tagReady) | setDirty | setValid;

  // Prefer an empty way, otherwise evict by LRU
  assign victimSel = ~valid0 ? 1'b0 : (~valid1 ? 1'b1 : lru[setQ]);

  assign lineWriteData = setValid ? memRdata : {(lineBytes/wordBytes){wdataQ}};
  assign lineByteMask  = lineMaskT'(lineMaskT'(byteEnQ) << (wordIdxQ * wordBytes));

  cacheWay way0 (
    .clk, .reset, .cacheEn, .set(setQ), .lookupTag(tagQ), .lineWriteData, .lineByteMask,
    .setValid, .setDirty, .clearDirty, .victimWay(~victimSel), .selWriteback,
    .invalidate(invalidateEn), .readDataLineWay(rdLine0), .hitWay(hit0),
    .validWay(valid0), .dirtyWay(dirty0), .tagWay(tag0)
  );

  cacheWay way1 (
    .clk, .reset, .cacheEn, .set(setQ), .lookupTag(tagQ), .lineWriteData, .lineByteMask,
    .setValid, .setDirty, .clearDirty, .victimWay(victimSel), .selWriteback,
    .invalidate(invalidateEn), .readDataLineWay(rdLine1), .hitWay(hit1),
    .validWay(valid1), .dirtyWay(dirty1), .tagWay(tag1)
  );

  // OR half of the way mux
  assign readLine    = rdLine0 | rdLine1;
  assign victimTag   = tag0 | tag1;
  assign victimDirty = dirty0 | dirty1;
  assign hit         = hit0 | hit1;

  assign rspRdata = readLine[wordIdxQ*$bits(wordT) +: $bits(wordT)];

  // Memory side, steady for the whole state
  assign memReq      = (state == writeback) | (state == fill);
  assign memWrite    = (state == writeback);
  assign memLineAddr = memWrite ? {victimTag, setQ} : {tagQ, setQ};
  assign memWdata    = readLine;  // Victim line while writing back

  //////////////////////////////
  // Controller FSM
  always_comb begin
    nextState = state;
    case (state)
      idle:      if (accept) nextState = lookup;
      lookup, relookup: begin
        if (hitNow) nextState = accept ? lookup : idle;  // Back-to-back hits
        else if (checking) nextState = victimDirty ? writeback : fill;
      end
      writeback: if (memDone) nextState = fill;
      fill:      if (memDone) nextState = relookup;
      default:   nextState = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= idle;
      tagReady <= 1'b0;
      lru      <= '0;
    end else begin
      state    <= nextState;
      tagReady <= inLookup & ~tagReady & (nextState == state);
      if (hitNow) lru[setQ] <= hit0;  // Other way becomes LRU
    end
  end

endmodule

// File: hw/memArbiter.sv
`timescale 1ns/1ps

module memArbiter (
  input  logic               clk,
  input  logic               reset,
  input  logic               req0,
  input  logic               write0,
  input  cachePkg::lineAddrT lineAddr0,
  input  cachePkg::lineT     wdata0,
  input  logic               req1,
  input  logic               write1,
  input  cachePkg::lineAddrT lineAddr1,
  input  cachePkg::lineT     wdata1,
  input  logic               memDoneIn,
  input  cachePkg::lineT     memRdataIn,
  output logic               done0,
  output logic               done1,
  output cachePkg::lineT     rdata0,
  output cachePkg::lineT     rdata1,
  output logic               memReqOut,
  output logic               memWriteOut,
  output cachePkg::lineAddrT memLineAddrOut,
  output cachePkg::lineT     memWdataOut
);

  logic grant0, grant1;
  logic lastServed;  // Cache served most recently

  // Grant held for a whole transaction, round robin on conflict
  always_ff @(posedge clk) begin
    if (reset) begin
      grant0     <= 1'b0;
      grant1     <= 1'b0;
      lastServed <= 1'b1;  // Cache 0 goes first
    end else if (grant0 | grant1) begin
      if (memDoneIn) begin
        grant0     <= 1'b0;
        grant1     <= 1'b0;
        lastServed <= grant1;
      end
    end else if (req0 & (~req1 | lastServed)) begin
      grant0 <= 1'b1;
    end else if (req1) begin
      grant1 <= 1'b1;
    end
  end

  // Bus mux
  assign memReqOut      = (grant0 & req0) | (grant1 & req1);
  assign memWriteOut    = grant1 ? write1 : write0;
  assign memLineAddrOut = grant1 ? lineAddr1 : lineAddr0;
  assign memWdataOut    = grant1 ? wdata1 : wdata0;

  // Completion only to the owner
  assign done0  = memDoneIn & grant0;
  assign done1  = memDoneIn & grant1;
  assign rdata0 = grant0 ? memRdataIn : '0;
  assign rdata1 = grant1 ? memRdataIn : '0;

endmodule

// File: hw/sramArray.sv
`timescale 1ns/1ps

module sramArray #(
  parameter type dataT = logic [7:0],
  parameter int  depth = 16
) (
  input  logic          clk,
  input  logic          ce,     // Enables read and write, dout holds when low
  input  cachePkg::setT addr,
  input  logic          we,
  input  dataT          wmask,  // Bit-level write mask
  input  dataT          din,
  output dataT          dout
);

  dataT mem [depth];

  // Read returns old contents when writing the same entry
  always_ff @(posedge clk) begin
    if (ce) begin
      dout <= mem[addr];
      if (we) begin
        mem[addr] <= (mem[addr] & ~wmask) | (din & wmask);  // Merge masked bits only
      end
    end
  end

endmodule

// File: tests/cacheTb.sv
`timescale 1ns/1ps

module cacheTb;

  import cachePkg::*;

  localparam int          testCount  = 7;
  localparam int          cycleLimit = testCount * 200;
  localparam int          randomOps  = 24;            // Per port
  localparam logic [15:0] lfsrSeed   = 16'd41;
  localparam addrT        base0      = 16'h0000;      // Port 0 region
  localparam addrT        base1      = 16'h8000;      // Port 1 region
  localparam int          dualLimit  = 2 * (2 * memLatency + 6);

  logic         clk = 1'b0;
  logic         reset, invalidate;
  logic [1:0]   reqValid, reqWrite, busy, rspValid;
  addrT [1:0]   reqAddr;
  wordT [1:0]   reqWdata, rspRdata;
  byteEnT [1:0] reqByteEn;

  wordT        shadow [2**(addrBits-2)];  // Expected memory, one entry per word
  logic [15:0] lfsrState;
  int          errors = 0, testsFailed = 0, cycleCount = 0;
  int          testErrStart, testBoundStart;

  // Pre-drawn random ops so forked ports never share the LFSR
  logic   opWrite  [2][randomOps];
  addrT   opAddr   [2][randomOps];
  wordT   opData   [2][randomOps];
  byteEnT opByteEn [2][randomOps];

  cacheTop uut (
    .clk, .reset, .invalidate,
    .p0ReqValid(reqValid[0]), .p0ReqWrite(reqWrite[0]), .p0ReqAddr(reqAddr[0]),
    .p0ReqWdata(reqWdata[0]), .p0ReqByteEn(reqByteEn[0]), .p0Busy(busy[0]),
    .p0RspValid(rspValid[0]), .p0RspRdata(rspRdata[0]),
    .p1ReqValid(reqValid[1]), .p1ReqWrite(reqWrite[1]), .p1ReqAddr(reqAddr[1]),
    .p1ReqWdata(reqWdata[1]), .p1ReqByteEn(reqByteEn[1]), .p1Busy(busy[1]),
    .p1RspValid(rspValid[1]), .p1RspRdata(rspRdata[1])
  );

  always #4 clk = ~clk;  // 8 ns period

  // Run limit
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout after %0d cycles, a request never completed", cycleCount);
      $display("Simulation failed");
      $finish;
    end
  end

  //////////////////////////////
  // Helpers
  function automatic logic nextRandomBit();
    logic fb;
    fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];  // x16+x14+x13+x11
    lfsrState = {lfsrState[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] randomBits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], nextRandomBit()};  // One step per bit
    return v;
  endfunction

  function automatic addrT lineAddress(int port, int tagSel, int setSel, int wordSel);
    addrT base;
    base = (port == 0) ? base0 : base1;
    return base | addrT'(tagSel * 256 + setSel * 16 + wordSel * 4);  // Tag, set, word
  endfunction

  function automatic wordT mergeBytes(wordT old, wordT data, byteEnT be);
    wordT merged;
    merged = old;
    for (int b = 0; b < wordBytes; b++) begin
      if (be[b]) merged[8*b +: 8] = data[8*b +: 8];
    end
    return merged;
  endfunction

  function automatic int boundFailures();
    return uut.arbiter.protocolCheck.failCount + uut.cache0.protocolCheck.failCount +
           uut.cache1.protocolCheck.failCount;
  endfunction

  // One request on one port, starts and ends 1 ns after an edge
  task automatic access(input int port, input logic write, input addrT addr,
                        input wordT wdata, input byteEnT be, input string name,
                        output int cycles);
    wordT expected;
    while (busy[port]) begin
      @(posedge clk);
      #1;
    end
    reqValid[port]  = 1'b1;
    reqWrite[port]  = write;
    reqAddr[port]   = addr;
    reqWdata[port]  = wdata;
    reqByteEn[port] = be;
    @(posedge clk);  // Accepted here
    #1;
    reqValid[port] = 1'b0;
    cycles = 1;
    while (!rspValid[port]) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (write) begin
      shadow[addr[addrBits-1:2]] = mergeBytes(shadow[addr[addrBits-1:2]], wdata, be);
    end else begin
      expected = shadow[addr[addrBits-1:2]];
      assert (rspRdata[port] === expected) else begin
        $display("MISMATCH %s addr %h expected %h actual %h", name, addr, expected,
                 rspRdata[port]);
        errors++;
      end
    end
  endtask

  task automatic runRandom(input int port);
    int cycles;
    for (int i = 0; i < randomOps; i++) begin
      access(port, opWrite[port][i], opAddr[port][i], opData[port][i], opByteEn[port][i],
             "randomRun", cycles);
    end
  endtask

  // Two fresh tags per set push every dirty line out
  task automatic readFreshTags(input int port);
    int cycles;
    for (int s = 0; s < numSets; s++) begin
      access(port, 1'b0, lineAddress(port, 3, s, 0), '0, 4'hF, "cleanFill", cycles);
      access(port, 1'b0, lineAddress(port, 4, s, 0), '0, 4'hF, "cleanFill", cycles);
    end
  endtask

  task automatic startTest();
    testErrStart   = errors;
    testBoundStart = boundFailures();
  endtask

  task automatic finishTest(input string name);
    int newErrors;
    newErrors = errors - testErrStart + boundFailures() - testBoundStart;
    if (newErrors == 0) begin
      $display("Test %s passed", name);
    end else begin
      $display("Test %s failed with %0d errors", name, newErrors);
      testsFailed++;
    end
  endtask

  //////////////////////////////
  // Stimulus
  initial begin
    int cycles, cycles0, cycles1;
    int tagSel, setSel, wordSel;
    reset      = 1'b1;
    invalidate = 1'b0;
    reqValid   = '0;
    reqWrite   = '0;
    reqAddr    = '0;
    reqWdata   = '0;
    reqByteEn  = '0;
    lfsrState  = lfsrSeed;
    for (int i = 0; i < 2**(addrBits-2); i++) shadow[i] = '0;  // Backing memory starts cleared

    for (int i = 0; i < randomOps; i++) begin
      for (int p = 0; p < 2; p++) begin
        opWrite[p][i]  = 1'(randomBits(1));
        tagSel         = int'(randomBits(2)) % 3;  // Three tags per set
        setSel         = int'(randomBits(4));
        wordSel        = int'(randomBits(2));
        opAddr[p][i]   = lineAddress(p, tagSel, setSel, wordSel);
        opData[p][i]   = randomBits(32);
        opByteEn[p][i] = 4'(randomBits(4));
        if (opByteEn[p][i] == 4'h0) opByteEn[p][i] = 4'hF;
      end
    end

    repeat (16) @(posedge clk);
    #1 reset = 1'b0;

    startTest();
    repeat (16) begin
      @(posedge clk);
      #1;
      assert (busy == 2'b00 && rspValid == 2'b00 && !uut.memReq0 && !uut.memReq1) else begin
        $display("Busy, response or memory request high right after reset");
        errors++;
      end
    end
    finishTest("resetQuiet");

    startTest();
    fork
      runRandom(0);
      runRandom(1);
    join
    finishTest("randomRun");

    startTest();  // Bytes 0 and 2 replaced, the rest kept
    access(0, 1'b1, lineAddress(0, 1, 9, 1), 32'h11223344, 4'hF, "byteEnable", cycles);
    access(0, 1'b1, lineAddress(0, 1, 9, 1), 32'hAABBCCDD, 4'b0101, "byteEnable", cycles);
    access(0, 1'b0, lineAddress(0, 1, 9, 1), '0, 4'hF, "byteEnable", cycles);
    finishTest("byteEnable");

    startTest();
    access(1, 1'b0, lineAddress(1, 2, 4, 0), '0, 4'hF, "backToBack", cycles);
    access(1, 1'b1, lineAddress(1, 2, 4, 3), 32'hCAFE0123, 4'hF, "backToBack", cycles);
    assert (cycles == 2) else begin
      $display("MISMATCH backToBack write latency expected 2 actual %0d", cycles);
      errors++;
    end
    access(1, 1'b0, lineAddress(1, 2, 4, 3), '0, 4'hF, "backToBack", cycles);
    assert (cycles == 2) else begin
      $display("MISMATCH backToBack read latency expected 2 actual %0d", cycles);
      errors++;
    end
    finishTest("backToBack");

    startTest();
    fork
      readFreshTags(0);
      readFreshTags(1);
    join
    finishTest("cleanFill");

    startTest();
    @(posedge clk);  // Both caches back in idle
    #1 invalidate = 1'b1;
    @(posedge clk);
    #1 invalidate = 1'b0;
    access(0, 1'b0, lineAddress(0, 3, 0, 0), '0, 4'hF, "invalidate", cycles0);
    access(1, 1'b0, lineAddress(1, 4, 0, 0), '0, 4'hF, "invalidate", cycles1);
    assert (cycles0 > 2 && cycles1 > 2) else begin
      $display("A read after invalidate hit in the cache (%0d and %0d cycles)", cycles0,
               cycles1);
      errors++;
    end
    access(0, 1'b0, lineAddress(0, 1, 9, 1), '0, 4'hF, "invalidate", cycles);  // Written back
    finishTest("invalidate");

    startTest();
    fork
      access(0, 1'b0, lineAddress(0, 5, 7, 2), '0, 4'hF, "dualMiss", cycles0);
      access(1, 1'b0, lineAddress(1, 5, 7, 2), '0, 4'hF, "dualMiss", cycles1);
    join
    assert (cycles0 <= dualLimit && cycles1 <= dualLimit) else begin
      $display("Simultaneous misses took too long (%0d and %0d cycles, limit %0d)",
               cycles0, cycles1, dualLimit);
      errors++;
    end
    finishTest("dualMiss");

    $display("Tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
             testCount, testsFailed, errors, boundFailures());
    if (testsFailed == 0 && errors == 0 && boundFailures() == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: tests/cacheTb_asserts.sv
`timescale 1ns/1ps

module memBusChecks (
  input logic               clk,
  input logic               reset,
  input logic               grantA,
  input logic               grantB,
  input logic               req,       // Requester side of the line bus
  input logic               write,
  input cachePkg::lineAddrT lineAddr,
  input cachePkg::lineT     wdata,
  input logic               done
);

  int failCount = 0;  // Read by the testbench at the end of each test

  //////////////////////////////
  // Arbiter grants
  grantsExclusive: assert property (@(posedge clk) disable iff (reset) !(grantA && grantB))
    else begin
      $error("both arbiter grants are high");
      failCount++;
    end

  //////////////////////////////
  // Request held until done
  reqHeld: assert property (@(posedge clk) disable iff (reset) req && !done |=> req)
    else begin
      $error("memory request dropped before done");
      failCount++;
    end

  // Write data only matters while writing back
  reqSteady: assert property (@(posedge clk) disable iff (reset)
      req && !done |=> $stable(write) && $stable(lineAddr) && (!write || $stable(wdata)))
    else begin
      $error("memory request changed before done");
      failCount++;
    end

  doneOnlyWithReq: assert property (@(posedge clk) disable iff (reset) done |-> req)
    else begin
      $error("done seen without a pending request");
      failCount++;
    end

endmodule

// Arbiter side sees the shared memory bus, each cache its own port
bind memArbiter memBusChecks protocolCheck (
  .clk, .reset, .grantA(grant0), .grantB(grant1), .req(memReqOut), .write(memWriteOut),
  .lineAddr(memLineAddrOut), .wdata(memWdataOut), .done(memDoneIn)
);

bind dataCache memBusChecks protocolCheck (
  .clk, .reset, .grantA(1'b0), .grantB(1'b0), .req(memReq), .write(memWrite),
  .lineAddr(memLineAddr), .wdata(memWdata), .done(memDone)
);

// File: verilog.f
hw/cachePkg.sv
hw/sramArray.sv
hw/cacheWay.sv
hw/dataCache.sv
hw/memArbiter.sv
hw/backingMem.sv
hw/cacheTop.sv
tests/cacheTb_asserts.sv
tests/cacheTb.sv
